// File: source/mrdo_video_pkg.sv
// shared types and constants for the tile video; raster constants are fixed to the original 5 MHz board timing
`default_nettype none

package mrdo_video_pkg;

	// raster geometry in pixels and lines
	localparam int H_TOTAL     = 320;
	localparam int H_VISIBLE   = 240;
	localparam int HSYNC_START = 256;
	localparam int HSYNC_LEN   = 32;
	localparam int V_TOTAL     = 262;
	localparam int V_VISIBLE   = 192;
	localparam int VSYNC_START = 220;
	localparam int VSYNC_LEN   = 3;

	// pixel enables from counter position to rgb output
	localparam int PIPE_LATENCY = 6;

	typedef logic [7:0]  pix_coord_t;
	typedef logic [8:0]  raster_cnt_t;
	typedef logic [8:0]  tile_code_t;
	typedef logic [7:0]  tile_attr_t;
	typedef logic [1:0]  pixel2_t;
	typedef logic [4:0]  pal_addr_t;
	typedef logic [11:0] rgb12_t;
	typedef logic [15:0] host_addr_t;
	typedef logic [7:0]  byte_t;

	typedef struct packed {
		pix_coord_t h;
		pix_coord_t v;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} raster_t;

	typedef struct packed {
		logic       strobe;
		host_addr_t addr;
		byte_t      data;
	} host_wr_t;

	typedef struct packed {
		pixel2_t    pix;
		tile_attr_t attr;
	} layer_pix_t;

	// h and v carry the full counts, so lines 256..261 read back correctly
	typedef struct packed {
		rgb12_t      rgb;
		raster_cnt_t h;
		raster_cnt_t v;
		logic        hblank;
		logic        vblank;
		logic        hsync;
		logic        vsync;
	} video_out_t;

	typedef enum logic {FG, BG} layer_sel_t;

	// bit positions inside the per-layer write strobe vector
	localparam int WE_ATTR   = 0;
	localparam int WE_INDEX  = 1;
	localparam int WE_PLANE0 = 2;
	localparam int WE_PLANE1 = 3;
	localparam int PAL_WE_HI = 0;
	localparam int PAL_WE_LO = 1;

	// host memory map, spans given as log2 of the region size
	localparam host_addr_t BG_PLANE0   = 16'h0000;
	localparam host_addr_t BG_PLANE1   = 16'h1000;
	localparam host_addr_t FG_PLANE0   = 16'h2000;
	localparam host_addr_t FG_PLANE1   = 16'h3000;
	localparam host_addr_t BG_ATTR     = 16'h8000;
	localparam host_addr_t BG_INDEX    = 16'h8400;
	localparam host_addr_t FG_ATTR     = 16'h8800;
	localparam host_addr_t FG_INDEX    = 16'h8C00;
	localparam host_addr_t PAL_HI      = 16'hE000;
	localparam host_addr_t PAL_LO      = 16'hE020;
	localparam host_addr_t SCROLL_BASE = 16'hF800;
	localparam int ROM_SPAN    = 12;
	localparam int RAM_SPAN    = 10;
	localparam int PAL_SPAN    = 5;
	localparam int SCROLL_SPAN = 11;

	// resistor ladder levels of the colour DAC, 8-bit scale
	localparam byte_t COLOR_LADDER [16] = '{
		8'd0,   8'd0,   8'd0,   8'd88,  8'd0,   8'd112, 8'd133, 8'd192,
		8'd60,  8'd150, 8'd166, 8'd212, 8'd180, 8'd221, 8'd229, 8'd255
	};

endpackage

`default_nettype wire

// File: source/video_timing.sv
// raster generator for a 10 MHz clock; pixel enable every second cycle, counters start at 0,0 after reset
`default_nettype none

module video_timing (
	input wire logic clk_10M,
	input wire logic RESET,
	output logic pix_ce,
	output mrdo_video_pkg::raster_t raster
);

	mrdo_video_pkg::raster_cnt_t h_cnt;
	mrdo_video_pkg::raster_cnt_t v_cnt;
	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (h_cnt == mrdo_video_pkg::raster_cnt_t'(mrdo_video_pkg::H_TOTAL - 1));
	assign v_wrap = (v_cnt == mrdo_video_pkg::raster_cnt_t'(mrdo_video_pkg::V_TOTAL - 1));

	// 5 MHz enable, low for the first cycle out of reset
	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			pix_ce <= 1'b0;
		end else begin
			pix_ce <= ~pix_ce;
		end
	end

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_ce) begin
			if (h_wrap) begin
				h_cnt <= '0;
				// next line on every horizontal wrap
				if (v_wrap) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// only the low byte of each count goes out, blanking covers the aliased part
	assign raster.h = h_cnt[7:0];
	assign raster.v = v_cnt[7:0];
	assign raster.hblank = (h_cnt >= mrdo_video_pkg::H_VISIBLE);
	assign raster.vblank = (v_cnt >= mrdo_video_pkg::V_VISIBLE);
	assign raster.hsync = (h_cnt >= mrdo_video_pkg::HSYNC_START) &&
		(h_cnt < mrdo_video_pkg::HSYNC_START + mrdo_video_pkg::HSYNC_LEN);
	assign raster.vsync = (v_cnt >= mrdo_video_pkg::VSYNC_START) &&
		(v_cnt < mrdo_video_pkg::VSYNC_START + mrdo_video_pkg::VSYNC_LEN);

	// counters never leave the frame
	a_h_in_range: assert property (@(posedge clk_10M) disable iff (RESET)
		h_cnt < mrdo_video_pkg::H_TOTAL && v_cnt < mrdo_video_pkg::V_TOTAL)
		else $error("raster counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

`default_nettype wire

// File: source/host_decode.sv
// host write decoder; writes are taken during reset too, unmapped addresses are dropped, scroll clears on reset
`default_nettype none

module host_decode (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire mrdo_video_pkg::host_wr_t host,
	output logic [3:0] fg_we,
	output logic [3:0] bg_we,
	output logic [1:0] pal_we,
	output mrdo_video_pkg::host_wr_t wr,
	output mrdo_video_pkg::pix_coord_t scroll
);

	logic scroll_hit;

	function automatic logic in_region(
		input mrdo_video_pkg::host_addr_t addr,
		input mrdo_video_pkg::host_addr_t base,
		input int span
	);
		return (addr >> span) == (base >> span);
	endfunction

	// one register stage, strobes line up with this copy
	always_ff @(posedge clk_10M) begin
		wr <= host;
	end

	always_comb begin
		fg_we = '0;
		bg_we = '0;
		pal_we = '0;
		bg_we[mrdo_video_pkg::WE_PLANE0] = in_region(wr.addr, mrdo_video_pkg::BG_PLANE0,
			mrdo_video_pkg::ROM_SPAN);
		bg_we[mrdo_video_pkg::WE_PLANE1] = in_region(wr.addr, mrdo_video_pkg::BG_PLANE1,
			mrdo_video_pkg::ROM_SPAN);
		fg_we[mrdo_video_pkg::WE_PLANE0] = in_region(wr.addr, mrdo_video_pkg::FG_PLANE0,
			mrdo_video_pkg::ROM_SPAN);
		fg_we[mrdo_video_pkg::WE_PLANE1] = in_region(wr.addr, mrdo_video_pkg::FG_PLANE1,
			mrdo_video_pkg::ROM_SPAN);
		bg_we[mrdo_video_pkg::WE_ATTR] = in_region(wr.addr, mrdo_video_pkg::BG_ATTR,
			mrdo_video_pkg::RAM_SPAN);
		bg_we[mrdo_video_pkg::WE_INDEX] = in_region(wr.addr, mrdo_video_pkg::BG_INDEX,
			mrdo_video_pkg::RAM_SPAN);
		fg_we[mrdo_video_pkg::WE_ATTR] = in_region(wr.addr, mrdo_video_pkg::FG_ATTR,
			mrdo_video_pkg::RAM_SPAN);
		fg_we[mrdo_video_pkg::WE_INDEX] = in_region(wr.addr, mrdo_video_pkg::FG_INDEX,
			mrdo_video_pkg::RAM_SPAN);
		pal_we[mrdo_video_pkg::PAL_WE_HI] = in_region(wr.addr, mrdo_video_pkg::PAL_HI,
			mrdo_video_pkg::PAL_SPAN);
		pal_we[mrdo_video_pkg::PAL_WE_LO] = in_region(wr.addr, mrdo_video_pkg::PAL_LO,
			mrdo_video_pkg::PAL_SPAN);
		scroll_hit = in_region(wr.addr, mrdo_video_pkg::SCROLL_BASE, mrdo_video_pkg::SCROLL_SPAN);
		// nothing fires without the registered strobe
		if (!wr.strobe) begin
			fg_we = '0;
			bg_we = '0;
			pal_we = '0;
			scroll_hit = 1'b0;
		end
	end

	// background vertical scroll latch
	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			scroll <= '0;
		end else if (scroll_hit) begin
			scroll <= wr.data;
		end
	end

	a_one_target: assert property (@(posedge clk_10M)
		$onehot0({fg_we, bg_we, pal_we, scroll_hit}))
		else $error("host write hit more than one target at %h", wr.addr);

endmodule

`default_nettype wire

// File: source/tile_layer.sv
// one playfield layer of 32x32 tiles; memories load only through host writes, BG rows follow the scroll register
`default_nettype none

module tile_layer #(
	parameter mrdo_video_pkg::layer_sel_t LAYER = mrdo_video_pkg::FG
) (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire logic pix_ce,
	input wire mrdo_video_pkg::raster_t raster,
	input wire mrdo_video_pkg::host_wr_t wr,
	input wire logic [3:0] we,
	input wire mrdo_video_pkg::pix_coord_t scroll,
	output mrdo_video_pkg::layer_pix_t lpix
);

	// fetch steps within each 8-pixel column
	// loading on step 4 puts pixel 8c out after exactly 5 enables
	localparam logic [2:0] STEP_INDEX = 3'd2;
	localparam logic [2:0] STEP_BITMAP = 3'd3;
	localparam logic [2:0] STEP_LOAD = 3'd4;

	mrdo_video_pkg::byte_t attr_ram [1024];
	mrdo_video_pkg::byte_t index_ram [1024];
	mrdo_video_pkg::byte_t plane0_rom [4096];
	mrdo_video_pkg::byte_t plane1_rom [4096];

	mrdo_video_pkg::pix_coord_t row;
	logic [9:0] char_index;
	logic [2:0] row_lo;
	mrdo_video_pkg::tile_attr_t attr_q;
	mrdo_video_pkg::byte_t index_q;
	mrdo_video_pkg::tile_code_t code;
	mrdo_video_pkg::tile_attr_t attr_hold;
	logic [11:0] bitmap_addr;
	mrdo_video_pkg::byte_t plane0_q;
	mrdo_video_pkg::byte_t plane1_q;
	mrdo_video_pkg::byte_t shift0;
	mrdo_video_pkg::byte_t shift1;
	mrdo_video_pkg::tile_attr_t attr_cur;

	// playfield row, wraps at 256 lines
	assign row = raster.v + ((LAYER == mrdo_video_pkg::BG) ? scroll : '0);

	// Host side writes and free running synchronous reads.
	// Reads settle in the idle cycle between two pixel enables.
	always_ff @(posedge clk_10M) begin
		if (we[mrdo_video_pkg::WE_ATTR]) begin
			attr_ram[wr.addr[9:0]] <= wr.data;
		end
		if (we[mrdo_video_pkg::WE_INDEX]) begin
			index_ram[wr.addr[9:0]] <= wr.data;
		end
		if (we[mrdo_video_pkg::WE_PLANE0]) begin
			plane0_rom[wr.addr[11:0]] <= wr.data;
		end
		if (we[mrdo_video_pkg::WE_PLANE1]) begin
			plane1_rom[wr.addr[11:0]] <= wr.data;
		end
		attr_q <= attr_ram[char_index];
		index_q <= index_ram[char_index];
		plane0_q <= plane0_rom[bitmap_addr];
		plane1_q <= plane1_rom[bitmap_addr];
	end

	// attribute bit 7 extends the index to 512 tiles
	assign code = {attr_q[7], index_q};

	always_ff @(posedge clk_10M) begin
		if (pix_ce) begin
			case (raster.h[2:0])
				STEP_INDEX: begin
					char_index <= {row[7:3], raster.h[7:3]};
					row_lo <= row[2:0];
				end
				STEP_BITMAP: begin
					bitmap_addr <= {code, row_lo};
					attr_hold <= attr_q;
				end
				default: begin
				end
			endcase
		end
	end

	// plane shifters, bit 0 leaves first
	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			shift0 <= '0;
			shift1 <= '0;
			attr_cur <= '0;
		end else if (pix_ce) begin
			if (raster.h[2:0] == STEP_LOAD) begin
				shift0 <= plane0_q;
				shift1 <= plane1_q;
				attr_cur <= attr_hold;
			end else begin
				shift0 <= {1'b0, shift0[7:1]};
				shift1 <= {1'b0, shift1[7:1]};
			end
		end
	end

	// attribute holds for the whole tile width
	assign lpix.pix = {shift1[0], shift0[0]};
	assign lpix.attr = attr_cur;

endmodule

`default_nettype wire

// File: source/color_mixer.sv
// fg over bg priority with palette PROM lookup; PROMs load only through host writes, output black while blanked
`default_nettype none

module color_mixer (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire logic pix_ce,
	input wire mrdo_video_pkg::raster_t raster,
	input wire mrdo_video_pkg::layer_pix_t fg,
	input wire mrdo_video_pkg::layer_pix_t bg,
	input wire mrdo_video_pkg::host_wr_t wr,
	input wire logic [1:0] pal_we,
	output mrdo_video_pkg::video_out_t video
);

	// raster stages to line up with the layer output
	localparam int DLY = mrdo_video_pkg::PIPE_LATENCY - 1;

	mrdo_video_pkg::byte_t pal_hi [32];
	mrdo_video_pkg::byte_t pal_lo [32];
	mrdo_video_pkg::raster_t raster_dly [DLY];
	mrdo_video_pkg::raster_t cur;
	mrdo_video_pkg::layer_pix_t win;
	logic draw;
	logic draw_q;
	mrdo_video_pkg::pal_addr_t hi_addr;
	mrdo_video_pkg::pal_addr_t lo_addr;
	mrdo_video_pkg::byte_t hi_q;
	mrdo_video_pkg::byte_t lo_q;

	function automatic logic [3:0] ladder(input logic [3:0] idx);
		return mrdo_video_pkg::COLOR_LADDER[idx][7:4];
	endfunction

	// a layer shows if its pixel is nonzero or it is forced opaque
	always_comb begin
		draw = 1'b1;
		if (fg.pix != '0 || fg.attr[6]) begin
			win = fg;
		end else if (bg.pix != '0 || bg.attr[6]) begin
			win = bg;
		end else begin
			win = '0;
			draw = 1'b0;
		end
	end

	assign hi_addr = {win.attr[2:0], win.pix};
	assign lo_addr = {win.attr[5:3], win.pix};

	// PROM read lands in the cycle between enables
	always_ff @(posedge clk_10M) begin
		if (pal_we[mrdo_video_pkg::PAL_WE_HI]) begin
			pal_hi[wr.addr[4:0]] <= wr.data;
		end
		if (pal_we[mrdo_video_pkg::PAL_WE_LO]) begin
			pal_lo[wr.addr[4:0]] <= wr.data;
		end
		hi_q <= pal_hi[hi_addr];
		lo_q <= pal_lo[lo_addr];
		draw_q <= draw;
	end

	always_ff @(posedge clk_10M) begin
		if (pix_ce) begin
			raster_dly[0] <= raster;
			for (int i = 1; i < DLY; i++) begin
				raster_dly[i] <= raster_dly[i - 1];
			end
		end
	end

	assign cur = raster_dly[DLY - 1];

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			video <= '0;
		end else if (pix_ce) begin
			if (cur.hblank || cur.vblank || !draw_q) begin
				video.rgb <= '0;
			end else begin
				video.rgb <= {ladder({hi_q[1:0], lo_q[1:0]}),
					ladder({hi_q[3:2], lo_q[3:2]}),
					ladder({hi_q[5:4], lo_q[5:4]})};
			end
			// a blanked low byte below the visible size means the count passed 255
			video.h <= {cur.hblank && (cur.h < mrdo_video_pkg::H_VISIBLE), cur.h};
			video.v <= {cur.vblank && (cur.v < mrdo_video_pkg::V_VISIBLE), cur.v};
			video.hblank <= cur.hblank;
			video.vblank <= cur.vblank;
			video.hsync <= cur.hsync;
			video.vsync <= cur.vsync;
		end
	end

endmodule

`default_nettype wire

// File: source/mrdo_video.sv
// tile video top; no sprites, no flip screen, memories hold unknown data until the host writes them
`default_nettype none

module mrdo_video (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire mrdo_video_pkg::host_wr_t host,
	output mrdo_video_pkg::video_out_t video
);

	logic pix_ce;
	mrdo_video_pkg::raster_t raster;
	mrdo_video_pkg::host_wr_t wr;
	logic [3:0] fg_we;
	logic [3:0] bg_we;
	logic [1:0] pal_we;
	mrdo_video_pkg::pix_coord_t scroll;
	mrdo_video_pkg::layer_pix_t fg_pix;
	mrdo_video_pkg::layer_pix_t bg_pix;

	video_timing i_video_timing (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.pix_ce(pix_ce),
		.raster(raster)
	);

	host_decode i_host_decode (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.host(host),
		.fg_we(fg_we),
		.bg_we(bg_we),
		.pal_we(pal_we),
		.wr(wr),
		.scroll(scroll)
	);

	tile_layer #(.LAYER(mrdo_video_pkg::FG)) fg_layer (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.pix_ce(pix_ce),
		.raster(raster),
		.wr(wr),
		.we(fg_we),
		.scroll(scroll),
		.lpix(fg_pix)
	);

	tile_layer #(.LAYER(mrdo_video_pkg::BG)) bg_layer (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.pix_ce(pix_ce),
		.raster(raster),
		.wr(wr),
		.we(bg_we),
		.scroll(scroll),
		.lpix(bg_pix)
	);

	color_mixer i_color_mixer (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.pix_ce(pix_ce),
		.raster(raster),
		.fg(fg_pix),
		.bg(bg_pix),
		.wr(wr),
		.pal_we(pal_we),
		.video(video)
	);

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
// compares each new output pixel with the model; a frame starts at h 0, v 0 and counts as one test
`default_nettype none

module tb_checker (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire mrdo_video_pkg::video_out_t video,
	input wire mrdo_video_pkg::byte_t model_mem [65536],
	input var int test_id,
	input wire logic check_en,
	output logic done,
	output logic timed_out,
	output int pass_cnt,
	output int fail_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = mrdo_video_pkg::H_TOTAL * mrdo_video_pkg::V_TOTAL * 2;
	// load frame, five test frames and the closing frame, plus slack
	localparam int CYCLE_LIMIT = 8 * FRAME_CYCLES + 10000;

	localparam logic [7:0] LEVELS [16] = '{
		8'd0, 8'd0, 8'd0, 8'd88, 8'd0, 8'd112, 8'd133, 8'd192,
		8'd60, 8'd150, 8'd166, 8'd212, 8'd180, 8'd221, 8'd229, 8'd255
	};
	string test_names [6] = '{"idle", "raster", "foreground", "bg_scroll",
		"force_opaque", "palette"};

	logic [17:0] last_pos;
	logic active;
	logic started;
	int cur_test;
	int errors;
	int pixels;
	int hsync_edges;
	int vsync_edges;
	int vsync_lines;
	logic hsync_q;
	logic vsync_q;
	int cycles;
	mrdo_video_pkg::rgb12_t exp_rgb;
	// hblank, vblank, hsync, vsync
	logic [3:0] exp_flags;

	function automatic mrdo_video_pkg::layer_pix_t layer_pixel(
		input mrdo_video_pkg::host_addr_t attr_base,
		input mrdo_video_pkg::host_addr_t index_base,
		input mrdo_video_pkg::host_addr_t p0_base,
		input mrdo_video_pkg::host_addr_t p1_base,
		input logic [7:0] h,
		input logic [7:0] row
	);
		logic [9:0] ci;
		logic [8:0] code;
		logic [11:0] ba;
		mrdo_video_pkg::layer_pix_t lp;
		ci = {row[7:3], h[7:3]};
		lp.attr = model_mem[attr_base + 16'(ci)];
		code = {lp.attr[7], model_mem[index_base + 16'(ci)]};
		ba = {code, row[2:0]};
		lp.pix = {model_mem[p1_base + 16'(ba)][h[2:0]], model_mem[p0_base + 16'(ba)][h[2:0]]};
		return lp;
	endfunction

	function automatic mrdo_video_pkg::rgb12_t expect_rgb(input logic [7:0] h, input logic [7:0] v);
		mrdo_video_pkg::layer_pix_t fg;
		mrdo_video_pkg::layer_pix_t bg;
		mrdo_video_pkg::layer_pix_t win;
		logic [7:0] row;
		logic [7:0] hi;
		logic [7:0] lo;
		row = v + model_mem[mrdo_video_pkg::SCROLL_BASE];
		fg = layer_pixel(mrdo_video_pkg::FG_ATTR, mrdo_video_pkg::FG_INDEX,
			mrdo_video_pkg::FG_PLANE0, mrdo_video_pkg::FG_PLANE1, h, v);
		bg = layer_pixel(mrdo_video_pkg::BG_ATTR, mrdo_video_pkg::BG_INDEX,
			mrdo_video_pkg::BG_PLANE0, mrdo_video_pkg::BG_PLANE1, h, row);
		if (fg.pix != 2'b00 || fg.attr[6]) begin
			win = fg;
		end else if (bg.pix != 2'b00 || bg.attr[6]) begin
			win = bg;
		end else begin
			return 12'h000;
		end
		hi = model_mem[mrdo_video_pkg::PAL_HI + 16'({win.attr[2:0], win.pix})];
		lo = model_mem[mrdo_video_pkg::PAL_LO + 16'({win.attr[5:3], win.pix})];
		return {LEVELS[{hi[1:0], lo[1:0]}][7:4], LEVELS[{hi[3:2], lo[3:2]}][7:4],
			LEVELS[{hi[5:4], lo[5:4]}][7:4]};
	endfunction

	task automatic finish_test();
		if (hsync_edges != mrdo_video_pkg::V_TOTAL) begin
			$display("[FAIL] %s hsync pulses expected %0d actual %0d",
				test_names[cur_test], mrdo_video_pkg::V_TOTAL, hsync_edges);
			errors++;
		end
		if (vsync_edges != 1 || vsync_lines != mrdo_video_pkg::VSYNC_LEN) begin
			$display("[FAIL] %s vsync pulses/lines expected 1/%0d actual %0d/%0d",
				test_names[cur_test], mrdo_video_pkg::VSYNC_LEN, vsync_edges, vsync_lines);
			errors++;
		end
		if (pixels != mrdo_video_pkg::H_TOTAL * mrdo_video_pkg::V_TOTAL) begin
			$display("[FAIL] %s pixels per frame expected %0d actual %0d", test_names[cur_test],
				mrdo_video_pkg::H_TOTAL * mrdo_video_pkg::V_TOTAL, pixels);
			errors++;
		end
		if (errors == 0) begin
			pass_cnt++;
			$display("test %s: ok", test_names[cur_test]);
		end else begin
			fail_cnt++;
			$display("test %s: %0d mismatches", test_names[cur_test], errors);
		end
	endtask

	// sample on the falling edge, away from the DUT updates
	always @(negedge clk_10M) begin
		if (RESET) begin
			last_pos = '1;
			active = 1'b0;
			started = 1'b0;
			done = 1'b0;
			pass_cnt = 0;
			fail_cnt = 0;
		end else if ({video.h, video.v} != last_pos) begin
			last_pos = {video.h, video.v};
			if (video.h == 9'd0 && video.v == 9'd0) begin
				if (active) begin
					finish_test();
				end
				active = check_en;
				cur_test = test_id;
				if (active) begin
					started = 1'b1;
				end else if (started) begin
					done = 1'b1;
				end
				errors = 0;
				pixels = 0;
				hsync_edges = 0;
				vsync_edges = 0;
				vsync_lines = 0;
				hsync_q = 1'b0;
				vsync_q = 1'b0;
			end
			if (active) begin
				pixels++;
				if (video.hsync && !hsync_q) begin
					hsync_edges++;
				end
				if (video.vsync && !vsync_q) begin
					vsync_edges++;
				end
				if (video.vsync && video.h == 9'd0) begin
					vsync_lines++;
				end
				hsync_q = video.hsync;
				vsync_q = video.vsync;
				// blanking and sync follow from the position alone
				exp_flags[3] = video.h >= mrdo_video_pkg::H_VISIBLE;
				exp_flags[2] = video.v >= mrdo_video_pkg::V_VISIBLE;
				exp_flags[1] = video.h >= mrdo_video_pkg::HSYNC_START &&
					video.h < mrdo_video_pkg::HSYNC_START + mrdo_video_pkg::HSYNC_LEN;
				exp_flags[0] = video.v >= mrdo_video_pkg::VSYNC_START &&
					video.v < mrdo_video_pkg::VSYNC_START + mrdo_video_pkg::VSYNC_LEN;
				if (exp_flags != {video.hblank, video.vblank, video.hsync, video.vsync}) begin
					errors++;
					if (errors <= 4) begin
						$display("[FAIL] %s blank/sync at h=%0d v=%0d expected %b actual %b",
							test_names[cur_test], video.h, video.v, exp_flags,
							{video.hblank, video.vblank, video.hsync, video.vsync});
					end
				end
				exp_rgb = 12'h000;
				if (!exp_flags[3] && !exp_flags[2]) begin
					exp_rgb = expect_rgb(video.h[7:0], video.v[7:0]);
				end
				if (exp_rgb != video.rgb) begin
					errors++;
					if (errors <= 4) begin
						$display("[FAIL] %s rgb at h=%0d v=%0d expected %h actual %h",
							test_names[cur_test], video.h, video.v, exp_rgb, video.rgb);
					end
				end
			end
		end
	end

	always @(posedge clk_10M) begin
		if (RESET) begin
			cycles <= 0;
			timed_out <= 1'b0;
		end else begin
			cycles <= cycles + 1;
			if (cycles == CYCLE_LIMIT && !timed_out) begin
				$display("timeout: the test frames did not finish within %0d cycles", CYCLE_LIMIT);
				timed_out <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_mrdo_video.sv
// testbench top; loads all memories with random data over the host port, then runs five checked frames
`default_nettype none

module tb_mrdo_video;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int OPAQUE_CELLS = 16;
	// host updates go in at this video line, inside vblank
	localparam int WRITE_LINE = 200;

	logic clk_10M;
	logic RESET;
	mrdo_video_pkg::host_wr_t host;
	mrdo_video_pkg::video_out_t video;
	mrdo_video_pkg::byte_t model_mem [65536];
	int test_id;
	logic check_en;
	logic done;
	logic timed_out;
	int pass_cnt;
	int fail_cnt;

	mrdo_video i_mrdo_video (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.host(host),
		.video(video)
	);

	tb_checker i_checker (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.video(video),
		.model_mem(model_mem),
		.test_id(test_id),
		.check_en(check_en),
		.done(done),
		.timed_out(timed_out),
		.pass_cnt(pass_cnt),
		.fail_cnt(fail_cnt)
	);

	initial begin
		clk_10M = 1'b0;
		forever #50 clk_10M = ~clk_10M;
	end

	// called 1 ns after a rising edge, returns 1 ns after the next one
	task automatic host_write(input mrdo_video_pkg::host_addr_t addr,
		input mrdo_video_pkg::byte_t data);
		host.strobe = 1'b1;
		host.addr = addr;
		host.data = data;
		model_mem[addr] = data;
		@(posedge clk_10M);
		#1;
		host.strobe = 1'b0;
	endtask

	task automatic fill_random(input mrdo_video_pkg::host_addr_t base, input int size);
		for (int i = 0; i < size; i++) begin
			host_write(base + 16'(i), 8'($urandom));
		end
	endtask

	// looks at the output 1 ns after each rising edge
	task automatic wait_for_line(input int line);
		do begin
			@(posedge clk_10M);
			#1;
		end while (video.v != 9'(line));
	endtask

	// same cell in both layers, zero bitmaps, opaque bit varied per layer
	task automatic rewrite_cells();
		int ci;
		mrdo_video_pkg::byte_t attr;
		logic [8:0] code;
		for (int n = 0; n < OPAQUE_CELLS; n++) begin
			ci = $urandom_range(1023);
			attr = 8'($urandom);
			attr[6] = n[0];
			host_write(mrdo_video_pkg::FG_ATTR + 16'(ci), attr);
			code = {attr[7], model_mem[mrdo_video_pkg::FG_INDEX + 16'(ci)]};
			for (int r = 0; r < 8; r++) begin
				host_write(mrdo_video_pkg::FG_PLANE0 + 16'({code, r[2:0]}), 8'h00);
				host_write(mrdo_video_pkg::FG_PLANE1 + 16'({code, r[2:0]}), 8'h00);
			end
			attr = 8'($urandom);
			attr[6] = n[1];
			host_write(mrdo_video_pkg::BG_ATTR + 16'(ci), attr);
			code = {attr[7], model_mem[mrdo_video_pkg::BG_INDEX + 16'(ci)]};
			for (int r = 0; r < 8; r++) begin
				host_write(mrdo_video_pkg::BG_PLANE0 + 16'({code, r[2:0]}), 8'h00);
				host_write(mrdo_video_pkg::BG_PLANE1 + 16'({code, r[2:0]}), 8'h00);
			end
		end
	endtask

	initial begin
		RESET = 1'b1;
		host = '0;
		test_id = 0;
		check_en = 1'b0;
		void'($urandom(32'h0679_d10b));
		for (int i = 0; i < 65536; i++) begin
			model_mem[i] = 8'h00;
		end
		@(posedge clk_10M);
		#1;
		// the load runs on past the end of reset
		fork
			begin
				repeat (RESET_CYCLES) @(posedge clk_10M);
				#1;
				RESET = 1'b0;
			end
			begin
				fill_random(mrdo_video_pkg::BG_PLANE0, 4096);
				fill_random(mrdo_video_pkg::BG_PLANE1, 4096);
				fill_random(mrdo_video_pkg::FG_PLANE0, 4096);
				fill_random(mrdo_video_pkg::FG_PLANE1, 4096);
				fill_random(mrdo_video_pkg::BG_ATTR, 1024);
				fill_random(mrdo_video_pkg::BG_INDEX, 1024);
				fill_random(mrdo_video_pkg::FG_ATTR, 1024);
				fill_random(mrdo_video_pkg::FG_INDEX, 1024);
				fill_random(mrdo_video_pkg::PAL_HI, 32);
				fill_random(mrdo_video_pkg::PAL_LO, 32);
			end
		join
		wait_for_line(WRITE_LINE);
		test_id = 1;
		check_en = 1'b1;
		wait_for_line(0);
		wait_for_line(WRITE_LINE);
		test_id = 2;
		wait_for_line(0);
		wait_for_line(WRITE_LINE);
		host_write(mrdo_video_pkg::SCROLL_BASE + 16'($urandom_range(2047)), 8'($urandom));
		// every alias of the register maps to one model byte
		model_mem[mrdo_video_pkg::SCROLL_BASE] = host.data;
		test_id = 3;
		wait_for_line(0);
		wait_for_line(WRITE_LINE);
		rewrite_cells();
		test_id = 4;
		wait_for_line(0);
		wait_for_line(WRITE_LINE);
		fill_random(mrdo_video_pkg::PAL_HI, 32);
		fill_random(mrdo_video_pkg::PAL_LO, 32);
		test_id = 5;
		wait_for_line(0);
		wait_for_line(WRITE_LINE);
		check_en = 1'b0;
		wait (done);
		#1;
		$display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == 5) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		wait (timed_out);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
source/mrdo_video_pkg.sv
source/video_timing.sv
source/host_decode.sv
source/tile_layer.sv
source/color_mixer.sv
source/mrdo_video.sv
tb/tb_checker.sv
tb/tb_mrdo_video.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_mrdo_video
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
